// File: src/core_pkg.sv
package core_pkg;

    // register value and address widths
    localparam int REG_DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;

    // architectural register numbering
    localparam int ARF_ID_WIDTH = 5;
    localparam int N_ARF_REGS = 1 << ARF_ID_WIDTH;

    typedef logic [REG_DATA_WIDTH-1:0] reg_data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [ARF_ID_WIDTH-1:0] arf_id_t;

    // one reorder buffer entry
    typedef struct packed {
        // instruction writes a register
        logic dst_valid;
        arf_id_t dst_arf_id;
        // dispatch pc, overwritten by the branch target at alu writeback
        addr_t pc_npc;
        logic br_mispred;
        // value produced or woken up, consumers may read it
        logic reg_ready;
        // instruction finished, eligible for retire at the head
        logic is_executed;
        reg_data_t reg_data;
    } rob_entry_t;

endpackage

// File: src/rob_ram.sv
module rob_ram #(
    parameter int ROB_DEPTH = 8,
    localparam int ID_W = $clog2(ROB_DEPTH)
) (
    input logic clk,
    input logic rst_n,

    // enqueue at the tail
    input logic enq_valid,
    output logic enq_ready,
    input core_pkg::rob_entry_t enq_data,
    output logic [ID_W-1:0] enq_id,

    // dequeue at the head
    output logic deq_valid,
    input logic deq_take,
    output core_pkg::rob_entry_t deq_data,
    output logic [ID_W-1:0] deq_id,

    // random read ports
    input logic [ID_W-1:0] rd_id1,
    input logic [ID_W-1:0] rd_id2,
    output core_pkg::rob_entry_t rd_data1,
    output core_pkg::rob_entry_t rd_data2,

    // random write ports, port 3 has the highest priority
    input logic [2:0] wr_en,
    input logic [ID_W-1:0] wr_id1,
    input logic [ID_W-1:0] wr_id2,
    input logic [ID_W-1:0] wr_id3,
    input core_pkg::rob_entry_t wr_data1,
    input core_pkg::rob_entry_t wr_data2,
    input core_pkg::rob_entry_t wr_data3,

    output core_pkg::rob_entry_t [ROB_DEPTH-1:0] entries,
    input logic flush
);

    // pointers carry one extra wrap bit to tell full from empty
    logic [ID_W:0] head;
    logic [ID_W:0] tail;
    core_pkg::rob_entry_t [ROB_DEPTH-1:0] mem;

    logic empty;
    logic full;
    logic enq_fire;
    logic deq_fire;

    assign empty = (head == tail);
    assign full = (head[ID_W] != tail[ID_W]) && (head[ID_W-1:0] == tail[ID_W-1:0]);

    // no enqueue while the buffer is being flushed
    assign enq_ready = !full && !flush;
    assign enq_id = tail[ID_W-1:0];
    assign enq_fire = enq_valid && enq_ready;

    assign deq_valid = !empty;
    assign deq_id = head[ID_W-1:0];
    assign deq_data = mem[head[ID_W-1:0]];
    assign deq_fire = deq_valid && deq_take;

    assign rd_data1 = mem[rd_id1];
    assign rd_data2 = mem[rd_id2];
    assign entries = mem;

    // pointer update
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
        end else if (flush) begin
            // drop everything younger than the head, restart just past it
            head <= head + 1'b1;
            tail <= head + 1'b1;
        end else begin
            if (enq_fire) begin
                tail <= tail + 1'b1;
            end
            if (deq_fire) begin
                head <= head + 1'b1;
            end
        end
    end

    // entry writes, later statements override earlier ones
    always_ff @(posedge clk) begin
        if (wr_en[0]) begin
            mem[wr_id1] <= wr_data1;
        end
        if (wr_en[1]) begin
            mem[wr_id2] <= wr_data2;
        end
        if (wr_en[2]) begin
            mem[wr_id3] <= wr_data3;
        end
        // tail slot is free, never collides with a live writeback
        if (enq_fire) begin
            mem[tail[ID_W-1:0]] <= enq_data;
        end
    end

endmodule

// File: src/rob.sv
module rob #(
    parameter int ROB_DEPTH = 8,
    localparam int ID_W = $clog2(ROB_DEPTH)
) (
    input logic clk,
    input logic rst_n,

    // dispatch, ready-then-valid
    input logic dispatch_valid,
    output logic dispatch_ready,
    output logic [ID_W-1:0] dispatch_rob_id,
    input logic dispatch_dst_valid,
    input core_pkg::arf_id_t dispatch_dst_arf_id,
    input core_pkg::addr_t dispatch_pc,

    // operand reads
    input logic [ID_W-1:0] src1_rob_id,
    input logic [ID_W-1:0] src2_rob_id,
    output logic src1_rob_ready,
    output core_pkg::reg_data_t src1_rob_data,
    output logic src2_rob_ready,
    output core_pkg::reg_data_t src2_rob_data,

    // integer wakeup
    input logic wakeup_valid,
    input logic [ID_W-1:0] wakeup_rob_id,

    // alu writeback
    input logic alu_wb_valid,
    input logic [ID_W-1:0] alu_wb_rob_id,
    input core_pkg::reg_data_t alu_wb_data,
    input logic alu_npc_valid,
    input logic alu_mispred,
    input core_pkg::addr_t alu_npc,

    // load writeback
    input logic ld_wb_valid,
    input logic [ID_W-1:0] ld_wb_rob_id,
    input core_pkg::reg_data_t ld_wb_data,

    // retire toward the arf and fetch
    output logic retire_valid,
    output logic retire_wb_arf_valid,
    output logic [ID_W-1:0] retire_rob_id,
    output core_pkg::arf_id_t retire_arf_id,
    output core_pkg::reg_data_t retire_reg_data,
    output logic retire_redirect_valid,
    output core_pkg::addr_t retire_redirect_pc
);

    core_pkg::rob_entry_t [ROB_DEPTH-1:0] rob_state;
    core_pkg::rob_entry_t dispatch_entry;
    core_pkg::rob_entry_t wakeup_entry;
    core_pkg::rob_entry_t alu_entry;
    core_pkg::rob_entry_t ld_entry;
    core_pkg::rob_entry_t head_entry;
    core_pkg::rob_entry_t rd_entry1;
    core_pkg::rob_entry_t rd_entry2;
    logic head_valid;

    // fresh entry, status flags clear and no data yet
    always_comb begin
        dispatch_entry = '0;
        dispatch_entry.dst_valid = dispatch_dst_valid;
        dispatch_entry.dst_arf_id = dispatch_dst_arf_id;
        dispatch_entry.pc_npc = dispatch_pc;
    end

    // each writeback merges into the current contents of its target
    always_comb begin
        wakeup_entry = rob_state[wakeup_rob_id];
        wakeup_entry.reg_ready = 1'b1;

        alu_entry = rob_state[alu_wb_rob_id];
        alu_entry.reg_data = alu_wb_data;
        alu_entry.is_executed = 1'b1;
        // branches also report their resolved target
        if (alu_npc_valid) begin
            alu_entry.pc_npc = alu_npc;
            alu_entry.br_mispred = alu_mispred;
        end

        ld_entry = rob_state[ld_wb_rob_id];
        ld_entry.reg_data = ld_wb_data;
        ld_entry.reg_ready = 1'b1;
        ld_entry.is_executed = 1'b1;
    end

    // write port order gives load over alu over wakeup
    rob_ram #(
        .ROB_DEPTH(ROB_DEPTH)
    ) rob_mem (
        .clk(clk),
        .rst_n(rst_n),
        .enq_valid(dispatch_valid),
        .enq_ready(dispatch_ready),
        .enq_data(dispatch_entry),
        .enq_id(dispatch_rob_id),
        .deq_valid(head_valid),
        .deq_take(head_entry.is_executed),
        .deq_data(head_entry),
        .deq_id(retire_rob_id),
        .rd_id1(src1_rob_id),
        .rd_id2(src2_rob_id),
        .rd_data1(rd_entry1),
        .rd_data2(rd_entry2),
        .wr_en({ld_wb_valid, alu_wb_valid, wakeup_valid}),
        .wr_id1(wakeup_rob_id),
        .wr_id2(alu_wb_rob_id),
        .wr_id3(ld_wb_rob_id),
        .wr_data1(wakeup_entry),
        .wr_data2(alu_entry),
        .wr_data3(ld_entry),
        .entries(rob_state),
        // a mispredict at the head empties the buffer
        .flush(retire_redirect_valid)
    );

    assign src1_rob_ready = rd_entry1.reg_ready;
    assign src1_rob_data = rd_entry1.reg_data;
    assign src2_rob_ready = rd_entry2.reg_ready;
    assign src2_rob_data = rd_entry2.reg_data;

    // head retires once it has executed
    assign retire_valid = head_valid && head_entry.is_executed;
    // mispredicted branches never update architectural state
    assign retire_wb_arf_valid = retire_valid && head_entry.dst_valid && !head_entry.br_mispred;
    assign retire_arf_id = head_entry.dst_arf_id;
    assign retire_reg_data = head_entry.reg_data;
    assign retire_redirect_valid = retire_valid && head_entry.br_mispred;
    assign retire_redirect_pc = head_entry.pc_npc;

endmodule

// File: src/rename_map.sv
module rename_map #(
    parameter int ROB_DEPTH = 8,
    localparam int ID_W = $clog2(ROB_DEPTH)
) (
    input logic clk,
    input logic rst_n,

    // new producer at dispatch
    input logic alloc_valid,
    input core_pkg::arf_id_t alloc_arf_id,
    input logic [ID_W-1:0] alloc_rob_id,

    // producer leaving at retire
    input logic retire_valid,
    input core_pkg::arf_id_t retire_arf_id,
    input logic [ID_W-1:0] retire_rob_id,

    input logic flush,

    // source lookups
    input core_pkg::arf_id_t src1_arf_id,
    input core_pkg::arf_id_t src2_arf_id,
    output logic src1_busy,
    output logic [ID_W-1:0] src1_rob_id,
    output logic src2_busy,
    output logic [ID_W-1:0] src2_rob_id
);

    // busy marks a register whose newest value still lives in the rob
    logic [core_pkg::N_ARF_REGS-1:0] busy;
    logic [ID_W-1:0] producer [core_pkg::N_ARF_REGS];
    logic retire_match;

    // only the newest producer may clear the mapping
    assign retire_match = retire_valid && busy[retire_arf_id]
        && (producer[retire_arf_id] == retire_rob_id);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= '0;
        end else if (flush) begin
            busy <= '0;
        end else begin
            if (retire_match) begin
                busy[retire_arf_id] <= 1'b0;
            end
            // dispatch to the same register overrides the retire clear
            if (alloc_valid) begin
                busy[alloc_arf_id] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            producer[alloc_arf_id] <= alloc_rob_id;
        end
    end

    assign src1_busy = busy[src1_arf_id];
    assign src1_rob_id = producer[src1_arf_id];
    assign src2_busy = busy[src2_arf_id];
    assign src2_rob_id = producer[src2_arf_id];

endmodule

// File: src/arf.sv
module arf (
    input logic clk,
    input logic rst_n,

    // retire write
    input logic wr_en,
    input core_pkg::arf_id_t wr_arf_id,
    input core_pkg::reg_data_t wr_data,

    // operand reads
    input core_pkg::arf_id_t rd_arf_id1,
    input core_pkg::arf_id_t rd_arf_id2,
    output core_pkg::reg_data_t rd_data1,
    output core_pkg::reg_data_t rd_data2
);

    core_pkg::reg_data_t regs [core_pkg::N_ARF_REGS];

    // committed state starts at zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < core_pkg::N_ARF_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_arf_id] <= wr_data;
        end
    end

    // reads see the old value during a same-cycle retire
    assign rd_data1 = regs[rd_arf_id1];
    assign rd_data2 = regs[rd_arf_id2];

endmodule

// File: src/operand_select.sv
module operand_select (
    // source 1
    input logic src1_busy,
    input logic src1_rob_ready,
    input core_pkg::reg_data_t src1_rob_data,
    input core_pkg::reg_data_t src1_arf_data,

    // source 2
    input logic src2_busy,
    input logic src2_rob_ready,
    input core_pkg::reg_data_t src2_rob_data,
    input core_pkg::reg_data_t src2_arf_data,

    output logic src1_ready,
    output core_pkg::reg_data_t src1_data,
    output logic src2_ready,
    output core_pkg::reg_data_t src2_data
);

    // no pending producer, the committed value is always ready
    assign src1_ready = src1_busy ? src1_rob_ready : 1'b1;
    assign src1_data = src1_busy ? src1_rob_data : src1_arf_data;

    // same choice for the second source
    assign src2_ready = src2_busy ? src2_rob_ready : 1'b1;
    assign src2_data = src2_busy ? src2_rob_data : src2_arf_data;

endmodule

// File: src/backend_top.sv
module backend_top #(
    parameter int ROB_DEPTH = 8,
    localparam int ID_W = $clog2(ROB_DEPTH)
) (
    input logic clk,
    input logic rst_n,

    // dispatch
    input logic dispatch_valid,
    output logic dispatch_ready,
    output logic [ID_W-1:0] dispatch_rob_id,
    input logic dispatch_dst_valid,
    input core_pkg::arf_id_t dispatch_dst_arf_id,
    input core_pkg::addr_t dispatch_pc,

    // writebacks
    input logic wakeup_valid,
    input logic [ID_W-1:0] wakeup_rob_id,
    input logic alu_wb_valid,
    input logic [ID_W-1:0] alu_wb_rob_id,
    input core_pkg::reg_data_t alu_wb_data,
    input logic alu_npc_valid,
    input logic alu_mispred,
    input core_pkg::addr_t alu_npc,
    input logic ld_wb_valid,
    input logic [ID_W-1:0] ld_wb_rob_id,
    input core_pkg::reg_data_t ld_wb_data,

    // retire
    output logic retire_valid,
    output logic retire_wb_arf_valid,
    output logic [ID_W-1:0] retire_rob_id,
    output core_pkg::arf_id_t retire_arf_id,
    output core_pkg::reg_data_t retire_reg_data,
    output logic retire_redirect_valid,
    output core_pkg::addr_t retire_redirect_pc,

    // operand reads
    input core_pkg::arf_id_t src1_arf_id,
    input core_pkg::arf_id_t src2_arf_id,
    output logic src1_ready,
    output core_pkg::reg_data_t src1_data,
    output logic src2_ready,
    output core_pkg::reg_data_t src2_data
);

    logic src1_busy;
    logic src2_busy;
    logic [ID_W-1:0] src1_rob_id;
    logic [ID_W-1:0] src2_rob_id;
    logic src1_rob_ready;
    logic src2_rob_ready;
    core_pkg::reg_data_t src1_rob_data;
    core_pkg::reg_data_t src2_rob_data;
    core_pkg::reg_data_t src1_arf_data;
    core_pkg::reg_data_t src2_arf_data;

    // only an accepted dispatch with a destination claims a register
    wire alloc_valid = dispatch_valid && dispatch_ready && dispatch_dst_valid;

    rename_map #(
        .ROB_DEPTH(ROB_DEPTH)
    ) rename0 (
        .clk(clk),
        .rst_n(rst_n),
        .alloc_valid(alloc_valid),
        .alloc_arf_id(dispatch_dst_arf_id),
        .alloc_rob_id(dispatch_rob_id),
        .retire_valid(retire_wb_arf_valid),
        .retire_arf_id(retire_arf_id),
        .retire_rob_id(retire_rob_id),
        .flush(retire_redirect_valid),
        .src1_arf_id(src1_arf_id),
        .src2_arf_id(src2_arf_id),
        .src1_busy(src1_busy),
        .src1_rob_id(src1_rob_id),
        .src2_busy(src2_busy),
        .src2_rob_id(src2_rob_id)
    );

    rob #(
        .ROB_DEPTH(ROB_DEPTH)
    ) rob0 (
        .clk(clk),
        .rst_n(rst_n),
        .dispatch_valid(dispatch_valid),
        .dispatch_ready(dispatch_ready),
        .dispatch_rob_id(dispatch_rob_id),
        .dispatch_dst_valid(dispatch_dst_valid),
        .dispatch_dst_arf_id(dispatch_dst_arf_id),
        .dispatch_pc(dispatch_pc),
        .src1_rob_id(src1_rob_id),
        .src2_rob_id(src2_rob_id),
        .src1_rob_ready(src1_rob_ready),
        .src1_rob_data(src1_rob_data),
        .src2_rob_ready(src2_rob_ready),
        .src2_rob_data(src2_rob_data),
        .wakeup_valid(wakeup_valid),
        .wakeup_rob_id(wakeup_rob_id),
        .alu_wb_valid(alu_wb_valid),
        .alu_wb_rob_id(alu_wb_rob_id),
        .alu_wb_data(alu_wb_data),
        .alu_npc_valid(alu_npc_valid),
        .alu_mispred(alu_mispred),
        .alu_npc(alu_npc),
        .ld_wb_valid(ld_wb_valid),
        .ld_wb_rob_id(ld_wb_rob_id),
        .ld_wb_data(ld_wb_data),
        .retire_valid(retire_valid),
        .retire_wb_arf_valid(retire_wb_arf_valid),
        .retire_rob_id(retire_rob_id),
        .retire_arf_id(retire_arf_id),
        .retire_reg_data(retire_reg_data),
        .retire_redirect_valid(retire_redirect_valid),
        .retire_redirect_pc(retire_redirect_pc)
    );

    arf arf0 (
        .clk(clk),
        .rst_n(rst_n),
        .wr_en(retire_wb_arf_valid),
        .wr_arf_id(retire_arf_id),
        .wr_data(retire_reg_data),
        .rd_arf_id1(src1_arf_id),
        .rd_arf_id2(src2_arf_id),
        .rd_data1(src1_arf_data),
        .rd_data2(src2_arf_data)
    );

    operand_select opsel0 (
        .src1_busy(src1_busy),
        .src1_rob_ready(src1_rob_ready),
        .src1_rob_data(src1_rob_data),
        .src1_arf_data(src1_arf_data),
        .src2_busy(src2_busy),
        .src2_rob_ready(src2_rob_ready),
        .src2_rob_data(src2_rob_data),
        .src2_arf_data(src2_arf_data),
        .src1_ready(src1_ready),
        .src1_data(src1_data),
        .src2_ready(src2_ready),
        .src2_data(src2_data)
    );

endmodule

// File: bench/tb_backend.sv
module tb_backend;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROB_DEPTH = 8;
    localparam int ID_W = $clog2(ROB_DEPTH);
    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 3;
    localparam int N_RANDOM = 3000;
    localparam int DRAIN_LIMIT = 64;
    localparam int SCRIPT_CYCLES = RESET_CYCLES + ROB_DEPTH + 3 + N_RANDOM + DRAIN_LIMIT;
    localparam logic [15:0] LFSR_SEED = 16'd16784;

    logic clk;
    logic rst_n;
    logic dispatch_valid;
    logic dispatch_ready;
    logic [ID_W-1:0] dispatch_rob_id;
    logic dispatch_dst_valid;
    core_pkg::arf_id_t dispatch_dst_arf_id;
    core_pkg::addr_t dispatch_pc;
    logic wakeup_valid;
    logic [ID_W-1:0] wakeup_rob_id;
    logic alu_wb_valid;
    logic [ID_W-1:0] alu_wb_rob_id;
    core_pkg::reg_data_t alu_wb_data;
    logic alu_npc_valid;
    logic alu_mispred;
    core_pkg::addr_t alu_npc;
    logic ld_wb_valid;
    logic [ID_W-1:0] ld_wb_rob_id;
    core_pkg::reg_data_t ld_wb_data;
    logic retire_valid;
    logic retire_wb_arf_valid;
    logic [ID_W-1:0] retire_rob_id;
    core_pkg::arf_id_t retire_arf_id;
    core_pkg::reg_data_t retire_reg_data;
    logic retire_redirect_valid;
    core_pkg::addr_t retire_redirect_pc;
    core_pkg::arf_id_t src1_arf_id;
    core_pkg::arf_id_t src2_arf_id;
    logic src1_ready;
    core_pkg::reg_data_t src1_data;
    logic src2_ready;
    core_pkg::reg_data_t src2_data;

    // values the DUT sees during the current cycle
    logic drv_dispatch_valid;
    logic drv_dst_valid;
    core_pkg::arf_id_t drv_dst;
    core_pkg::addr_t drv_pc;
    logic drv_wakeup_valid;
    logic [ID_W-1:0] drv_wakeup_id;
    logic drv_alu_valid;
    logic [ID_W-1:0] drv_alu_id;
    core_pkg::reg_data_t drv_alu_data;
    logic drv_alu_npc_valid;
    logic drv_alu_mispred;
    core_pkg::addr_t drv_alu_npc;
    logic drv_ld_valid;
    logic [ID_W-1:0] drv_ld_id;
    core_pkg::reg_data_t drv_ld_data;
    core_pkg::arf_id_t drv_src1;
    core_pkg::arf_id_t drv_src2;

    // reference model, one slot per rob id
    logic m_dst_valid [ROB_DEPTH];
    core_pkg::arf_id_t m_dst [ROB_DEPTH];
    core_pkg::reg_data_t m_data [ROB_DEPTH];
    core_pkg::addr_t m_npc [ROB_DEPTH];
    logic m_mispred [ROB_DEPTH];
    logic m_ready [ROB_DEPTH];
    logic m_exec [ROB_DEPTH];
    // outstanding ids, oldest first
    int order_q[$];
    int next_id;
    core_pkg::reg_data_t m_arf [core_pkg::N_ARF_REGS];
    logic m_busy [core_pkg::N_ARF_REGS];
    int m_prod [core_pkg::N_ARF_REGS];
    core_pkg::addr_t pc_count;
    logic [15:0] lfsr;

    // predicted outputs for the current cycle
    logic exp_dispatch_ready;
    logic [ID_W-1:0] exp_dispatch_rob_id;
    logic exp_retire_valid;
    logic [ID_W-1:0] exp_retire_rob_id;
    core_pkg::reg_data_t exp_retire_data;
    logic exp_wb;
    core_pkg::arf_id_t exp_arf_id;
    logic exp_redirect;
    core_pkg::addr_t exp_redirect_pc;
    logic exp_src1_ready;
    core_pkg::reg_data_t exp_src1_data;
    logic exp_src2_ready;
    core_pkg::reg_data_t exp_src2_data;

    backend_top #(
        .ROB_DEPTH(ROB_DEPTH)
    ) dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .dispatch_valid(dispatch_valid),
        .dispatch_ready(dispatch_ready),
        .dispatch_rob_id(dispatch_rob_id),
        .dispatch_dst_valid(dispatch_dst_valid),
        .dispatch_dst_arf_id(dispatch_dst_arf_id),
        .dispatch_pc(dispatch_pc),
        .wakeup_valid(wakeup_valid),
        .wakeup_rob_id(wakeup_rob_id),
        .alu_wb_valid(alu_wb_valid),
        .alu_wb_rob_id(alu_wb_rob_id),
        .alu_wb_data(alu_wb_data),
        .alu_npc_valid(alu_npc_valid),
        .alu_mispred(alu_mispred),
        .alu_npc(alu_npc),
        .ld_wb_valid(ld_wb_valid),
        .ld_wb_rob_id(ld_wb_rob_id),
        .ld_wb_data(ld_wb_data),
        .retire_valid(retire_valid),
        .retire_wb_arf_valid(retire_wb_arf_valid),
        .retire_rob_id(retire_rob_id),
        .retire_arf_id(retire_arf_id),
        .retire_reg_data(retire_reg_data),
        .retire_redirect_valid(retire_redirect_valid),
        .retire_redirect_pc(retire_redirect_pc),
        .src1_arf_id(src1_arf_id),
        .src2_arf_id(src2_arf_id),
        .src1_ready(src1_ready),
        .src1_data(src1_data),
        .src2_ready(src2_ready),
        .src2_data(src2_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                 $time, name, expected, actual);
        stop_with_failure();
    endtask

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    task automatic predict_operand(input core_pkg::arf_id_t r, output logic ready,
                                   output core_pkg::reg_data_t data);
        // pending producer answers from its rob entry, else committed value
        if (m_busy[r]) begin
            ready = m_ready[m_prod[r]];
            data = m_data[m_prod[r]];
        end else begin
            ready = 1'b1;
            data = m_arf[r];
        end
    endtask

    task automatic predict_outputs();
        int head;
        exp_dispatch_rob_id = ID_W'(next_id);
        exp_retire_valid = 1'b0;
        exp_retire_rob_id = '0;
        exp_retire_data = '0;
        exp_wb = 1'b0;
        exp_arf_id = '0;
        exp_redirect = 1'b0;
        exp_redirect_pc = '0;
        if (order_q.size() > 0) begin
            head = order_q[0];
            exp_retire_rob_id = ID_W'(head);
            exp_retire_data = m_data[head];
            exp_arf_id = m_dst[head];
            exp_redirect_pc = m_npc[head];
            exp_retire_valid = m_exec[head];
            exp_wb = m_exec[head] && m_dst_valid[head] && !m_mispred[head];
            exp_redirect = m_exec[head] && m_mispred[head];
        end
        // full buffer or flush in progress refuses dispatch
        exp_dispatch_ready = (order_q.size() < ROB_DEPTH) && !exp_redirect;
        predict_operand(drv_src1, exp_src1_ready, exp_src1_data);
        predict_operand(drv_src2, exp_src2_ready, exp_src2_data);
    endtask

    // model state after the edge, from the inputs sampled at it
    task automatic update_model();
        int head;
        int id;
        // load goes last so it overrides an alu result on the same id
        if (drv_wakeup_valid) begin
            m_ready[drv_wakeup_id] = 1'b1;
        end
        if (drv_alu_valid) begin
            m_data[drv_alu_id] = drv_alu_data;
            m_exec[drv_alu_id] = 1'b1;
            if (drv_alu_npc_valid) begin
                m_npc[drv_alu_id] = drv_alu_npc;
                m_mispred[drv_alu_id] = drv_alu_mispred;
            end
        end
        if (drv_ld_valid) begin
            m_data[drv_ld_id] = drv_ld_data;
            m_ready[drv_ld_id] = 1'b1;
            m_exec[drv_ld_id] = 1'b1;
        end
        if (exp_retire_valid) begin
            head = order_q.pop_front();
            if (exp_wb) begin
                m_arf[exp_arf_id] = exp_retire_data;
                if (m_busy[exp_arf_id] && m_prod[exp_arf_id] == head) begin
                    m_busy[exp_arf_id] = 1'b0;
                end
            end
            // mispredict drops every younger entry and mapping
            if (exp_redirect) begin
                order_q.delete();
                next_id = (head + 1) % ROB_DEPTH;
                foreach (m_busy[r]) begin
                    m_busy[r] = 1'b0;
                end
            end
        end
        if (drv_dispatch_valid && exp_dispatch_ready) begin
            id = next_id;
            m_dst_valid[id] = drv_dst_valid;
            m_dst[id] = drv_dst;
            m_npc[id] = drv_pc;
            m_data[id] = '0;
            m_mispred[id] = 1'b0;
            m_ready[id] = 1'b0;
            m_exec[id] = 1'b0;
            order_q.push_back(id);
            next_id = (id + 1) % ROB_DEPTH;
            if (drv_dst_valid) begin
                m_busy[drv_dst] = 1'b1;
                m_prod[drv_dst] = id;
            end
        end
    endtask

    task automatic drive_inputs();
        dispatch_valid <= drv_dispatch_valid;
        dispatch_dst_valid <= drv_dst_valid;
        dispatch_dst_arf_id <= drv_dst;
        dispatch_pc <= drv_pc;
        wakeup_valid <= drv_wakeup_valid;
        wakeup_rob_id <= drv_wakeup_id;
        alu_wb_valid <= drv_alu_valid;
        alu_wb_rob_id <= drv_alu_id;
        alu_wb_data <= drv_alu_data;
        alu_npc_valid <= drv_alu_npc_valid;
        alu_mispred <= drv_alu_mispred;
        alu_npc <= drv_alu_npc;
        ld_wb_valid <= drv_ld_valid;
        ld_wb_rob_id <= drv_ld_id;
        ld_wb_data <= drv_ld_data;
        src1_arf_id <= drv_src1;
        src2_arf_id <= drv_src2;
    endtask

    task automatic run_cycle(input bit dispatch_on, input bit wb_on);
        int wake_q[$];
        int alu_q[$];
        int k;
        bit collided;
        @(posedge clk);
        update_model();
        drv_wakeup_valid = 1'b0;
        drv_alu_valid = 1'b0;
        drv_alu_npc_valid = 1'b0;
        drv_alu_mispred = 1'b0;
        drv_ld_valid = 1'b0;
        collided = 1'b0;
        // without writebacks every cycle offers a dispatch
        drv_dispatch_valid = dispatch_on && (!wb_on || rand_bits(2) != 0);
        drv_dst_valid = rand_bits(2) != 0;
        drv_dst = core_pkg::arf_id_t'(rand_bits(3));
        drv_pc = pc_count;
        pc_count = pc_count + 32'd4;
        drv_src1 = core_pkg::arf_id_t'(rand_bits(3));
        drv_src2 = core_pkg::arf_id_t'(rand_bits(3));
        if (wb_on) begin
            // not yet woken entries take a wakeup or a load, woken ones the alu
            foreach (order_q[i]) begin
                if (!m_exec[order_q[i]] && !m_ready[order_q[i]]) begin
                    wake_q.push_back(order_q[i]);
                end
                if (!m_exec[order_q[i]] && m_ready[order_q[i]]) begin
                    alu_q.push_back(order_q[i]);
                end
            end
            if (wake_q.size() > 0 && rand_bits(1) != 0) begin
                k = int'(rand_bits(8)) % wake_q.size();
                drv_ld_valid = 1'b1;
                drv_ld_id = ID_W'(wake_q[k]);
                drv_ld_data = rand_bits(32);
                wake_q.delete(k);
                // alu result racing the load on one id
                if (rand_bits(2) == 0) begin
                    collided = 1'b1;
                    drv_alu_valid = 1'b1;
                    drv_alu_id = drv_ld_id;
                    drv_alu_data = ~drv_ld_data;
                end
            end
            if (wake_q.size() > 0 && rand_bits(1) != 0) begin
                k = int'(rand_bits(8)) % wake_q.size();
                drv_wakeup_valid = 1'b1;
                drv_wakeup_id = ID_W'(wake_q[k]);
            end
            if (!collided && alu_q.size() > 0 && rand_bits(1) != 0) begin
                k = int'(rand_bits(8)) % alu_q.size();
                drv_alu_valid = 1'b1;
                drv_alu_id = ID_W'(alu_q[k]);
                drv_alu_data = rand_bits(32);
                // one in four is a branch, one branch in four mispredicts
                drv_alu_npc_valid = rand_bits(2) == 0;
                drv_alu_mispred = drv_alu_npc_valid && rand_bits(2) == 0;
                drv_alu_npc = rand_bits(30) << 2;
            end
        end
        drive_inputs();
        predict_outputs();
    endtask

    // all checks sample at the falling edge, away from input changes
    assert property (@(negedge clk) disable iff (!rst_n)
        dispatch_ready == exp_dispatch_ready)
        else report_mismatch("dispatch_ready", 32'(exp_dispatch_ready), 32'(dispatch_ready));
    assert property (@(negedge clk) disable iff (!rst_n)
        dispatch_ready |-> dispatch_rob_id == exp_dispatch_rob_id)
        else report_mismatch("dispatch_rob_id", 32'(exp_dispatch_rob_id),
                             32'(dispatch_rob_id));
    assert property (@(negedge clk) disable iff (!rst_n)
        retire_valid == exp_retire_valid)
        else report_mismatch("retire_valid", 32'(exp_retire_valid), 32'(retire_valid));
    assert property (@(negedge clk) disable iff (!rst_n)
        retire_valid |-> retire_rob_id == exp_retire_rob_id)
        else report_mismatch("retire_rob_id", 32'(exp_retire_rob_id), 32'(retire_rob_id));
    assert property (@(negedge clk) disable iff (!rst_n)
        retire_valid |-> retire_reg_data == exp_retire_data)
        else report_mismatch("retire_reg_data", exp_retire_data, retire_reg_data);
    assert property (@(negedge clk) disable iff (!rst_n)
        retire_wb_arf_valid == exp_wb)
        else report_mismatch("retire_wb_arf_valid", 32'(exp_wb), 32'(retire_wb_arf_valid));
    assert property (@(negedge clk) disable iff (!rst_n)
        retire_wb_arf_valid |-> retire_arf_id == exp_arf_id)
        else report_mismatch("retire_arf_id", 32'(exp_arf_id), 32'(retire_arf_id));
    assert property (@(negedge clk) disable iff (!rst_n)
        retire_redirect_valid == exp_redirect)
        else report_mismatch("retire_redirect_valid", 32'(exp_redirect),
                             32'(retire_redirect_valid));
    assert property (@(negedge clk) disable iff (!rst_n)
        retire_redirect_valid |-> retire_redirect_pc == exp_redirect_pc)
        else report_mismatch("retire_redirect_pc", exp_redirect_pc, retire_redirect_pc);
    assert property (@(negedge clk) disable iff (!rst_n)
        src1_ready == exp_src1_ready)
        else report_mismatch("src1_ready", 32'(exp_src1_ready), 32'(src1_ready));
    assert property (@(negedge clk) disable iff (!rst_n)
        src1_data == exp_src1_data)
        else report_mismatch("src1_data", exp_src1_data, src1_data);
    assert property (@(negedge clk) disable iff (!rst_n)
        src2_ready == exp_src2_ready)
        else report_mismatch("src2_ready", 32'(exp_src2_ready), 32'(src2_ready));
    assert property (@(negedge clk) disable iff (!rst_n)
        src2_data == exp_src2_data)
        else report_mismatch("src2_data", exp_src2_data, src2_data);

    // watchdog, ten times the scripted length
    initial begin
        #(10 * SCRIPT_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", 10 * SCRIPT_CYCLES);
        stop_with_failure();
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        lfsr = LFSR_SEED;
        pc_count = 32'h0000_1000;
        next_id = 0;
        order_q.delete();
        foreach (m_arf[r]) begin
            m_arf[r] = '0;
            m_busy[r] = 1'b0;
            m_prod[r] = 0;
        end
        foreach (m_exec[i]) begin
            m_exec[i] = 1'b0;
            m_ready[i] = 1'b0;
        end
        drv_dispatch_valid = 1'b0;
        drv_dst_valid = 1'b0;
        drv_dst = '0;
        drv_pc = '0;
        drv_wakeup_valid = 1'b0;
        drv_wakeup_id = '0;
        drv_alu_valid = 1'b0;
        drv_alu_id = '0;
        drv_alu_data = '0;
        drv_alu_npc_valid = 1'b0;
        drv_alu_mispred = 1'b0;
        drv_alu_npc = '0;
        drv_ld_valid = 1'b0;
        drv_ld_id = '0;
        drv_ld_data = '0;
        drv_src1 = '0;
        drv_src2 = '0;
        drive_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        predict_outputs();
        // fill the buffer, then hold it full for a few cycles
        repeat (ROB_DEPTH + 3) run_cycle(1'b1, 1'b0);
        // out of order writebacks with dispatch, mispredicts and collisions
        repeat (N_RANDOM) run_cycle(1'b1, 1'b1);
        // drain whatever is still outstanding
        while (order_q.size() != 0) begin
            run_cycle(1'b0, 1'b1);
        end
        repeat (2) run_cycle(1'b0, 1'b0);
        @(negedge clk);
        #1;
        $display("Test passed");
        $finish;
    end

endmodule

// File: all.f
src/core_pkg.sv
src/rob_ram.sv
src/rob.sv
src/rename_map.sv
src/arf.sv
src/operand_select.sv
src/backend_top.sv
bench/tb_backend.sv

// File: Makefile
BUILD_DIR := build
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -f all.f --top-module tb_backend \
		-Mdir $(BUILD_DIR) -o sim
	./$(BUILD_DIR)/sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
